// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int XLEN      = 32;
	localparam int REG_AW    = 5;
	localparam int MEM_WORDS = 256; // data ram depth in words.

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b // lui.
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc_four
	} wb_sel_e;

	typedef enum logic [2:0] {
		ls_byte,
		ls_half,
		ls_word,
		ls_byte_u,
		ls_half_u
	} ls_size_e;

endpackage

`default_nettype wire

// ==== alu_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
	input  rv_pkg::alu_op_e          i_alu_op,
	input  logic [rv_pkg::XLEN-1:0]  i_opa,
	input  logic [rv_pkg::XLEN-1:0]  i_opb,
	input  logic [rv_pkg::XLEN-1:0]  i_pre_opb,
	input  rv_pkg::ls_size_e         i_sl_sel,
	output logic [rv_pkg::XLEN-1:0]  o_alu_data,
	output logic [3:0]               o_bmask,
	output logic [rv_pkg::XLEN-1:0]  o_store_data
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic [1:0] lane;

	assign shamt = i_opb[4:0];
	assign lane  = o_alu_data[1:0]; // address offset inside the word.

	always_comb begin
		case (i_alu_op)
			alu_add:    o_alu_data = i_opa + i_opb;
			alu_sub:    o_alu_data = i_opa - i_opb;
			alu_and:    o_alu_data = i_opa & i_opb;
			alu_or:     o_alu_data = i_opa | i_opb;
			alu_xor:    o_alu_data = i_opa ^ i_opb;
			alu_sll:    o_alu_data = i_opa << shamt;
			alu_srl:    o_alu_data = i_opa >> shamt;
			alu_sra:    o_alu_data = $signed(i_opa) >>> shamt;
			alu_slt:    o_alu_data = {{(XLEN-1){1'b0}}, $signed(i_opa) < $signed(i_opb)};
			alu_sltu:   o_alu_data = {{(XLEN-1){1'b0}}, i_opa < i_opb};
			alu_pass_b: o_alu_data = i_opb;
			default:    o_alu_data = '0;
		endcase
	end

	always_comb begin
		case (i_sl_sel)
			ls_byte, ls_byte_u: begin
				o_bmask      = 4'b0001 << lane;
				o_store_data = i_pre_opb << {lane, 3'b000};
			end
			ls_half, ls_half_u: begin
				o_bmask      = 4'b0011 << {lane[1], 1'b0};
				o_store_data = i_pre_opb << {lane[1], 4'b0000};
			end
			default: begin // full word.
				o_bmask      = 4'b1111;
				o_store_data = i_pre_opb;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== flip_flop_execute_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module flip_flop_execute_memory (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_stall,
	input  logic [rv_pkg::XLEN-1:0]   i_pc_execute,
	input  logic [rv_pkg::XLEN-1:0]   i_pc_four_execute,
	input  logic                      i_rd_wren_execute,
	input  logic                      i_insn_vld_execute,
	input  logic                      i_mem_wren_execute,
	input  rv_pkg::wb_sel_e           i_wb_sel_execute,
	input  rv_pkg::ls_size_e          i_sl_sel_execute,
	input  logic [3:0]                i_bmask_execute,
	input  logic [rv_pkg::XLEN-1:0]   i_alu_data_execute,
	input  logic [rv_pkg::REG_AW-1:0] i_rd_addr_execute,
	input  logic [rv_pkg::XLEN-1:0]   i_pre_opb_execute,
	output logic [rv_pkg::XLEN-1:0]   o_pc_memory,
	output logic [rv_pkg::XLEN-1:0]   o_pc_four_memory,
	output logic                      o_rd_wren_memory,
	output logic                      o_insn_vld_memory,
	output logic                      o_mem_wren_memory,
	output rv_pkg::wb_sel_e           o_wb_sel_memory,
	output rv_pkg::ls_size_e          o_sl_sel_memory,
	output logic [3:0]                o_bmask_memory,
	output logic [rv_pkg::XLEN-1:0]   o_alu_data_memory,
	output logic [rv_pkg::REG_AW-1:0] o_rd_addr_memory,
	output logic [rv_pkg::XLEN-1:0]   o_pre_opb_memory
);
	import rv_pkg::*;

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (~i_reset) begin
			o_pc_memory       <= '0;
			o_pc_four_memory  <= '0;
			o_rd_wren_memory  <= 1'b0;
			o_insn_vld_memory <= 1'b0;
			o_mem_wren_memory <= 1'b0;
			o_wb_sel_memory   <= wb_alu;
			o_sl_sel_memory   <= ls_byte;
			o_bmask_memory    <= '0;
			o_alu_data_memory <= '0;
			o_rd_addr_memory  <= '0;
			o_pre_opb_memory  <= '0;
		end else if (~i_stall) begin // hold everything while the lsu waits.
			o_pc_memory       <= i_pc_execute;
			o_pc_four_memory  <= i_pc_four_execute;
			o_rd_wren_memory  <= i_rd_wren_execute;
			o_insn_vld_memory <= i_insn_vld_execute;
			o_mem_wren_memory <= i_mem_wren_execute;
			o_wb_sel_memory   <= i_wb_sel_execute;
			o_sl_sel_memory   <= i_sl_sel_execute;
			o_bmask_memory    <= i_bmask_execute;
			o_alu_data_memory <= i_alu_data_execute;
			o_rd_addr_memory  <= i_rd_addr_execute;
			o_pre_opb_memory  <= i_pre_opb_execute;
		end
	end

endmodule

`default_nettype wire

// ==== lsu_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_memory (
	input  logic                     i_insn_vld,
	input  logic                     i_mem_wren,
	input  rv_pkg::wb_sel_e          i_wb_sel,
	input  rv_pkg::ls_size_e         i_sl_sel,
	input  logic [3:0]               i_bmask,
	input  logic [rv_pkg::XLEN-1:0]  i_addr,
	input  logic [rv_pkg::XLEN-1:0]  i_store_data,
	input  logic [rv_pkg::XLEN-1:0]  i_wb_dat_i,
	input  logic                     i_wb_ack,
	output logic                     o_wb_cyc,
	output logic                     o_wb_stb,
	output logic                     o_wb_we,
	output logic [3:0]               o_wb_sel,
	output logic [rv_pkg::XLEN-1:0]  o_wb_adr,
	output logic [rv_pkg::XLEN-1:0]  o_wb_dat_o,
	output logic                     o_stall,
	output logic [rv_pkg::XLEN-1:0]  o_load_data
);
	import rv_pkg::*;

	logic            access;
	logic [XLEN-1:0] shifted;

	// loads and stores both go out on the bus.
	assign access = i_insn_vld & ((i_wb_sel == wb_mem) | i_mem_wren);

	// ex/mem holds steady while stalled, so the bus signals stay put until ack.
	assign o_wb_cyc   = access;
	assign o_wb_stb   = access;
	assign o_wb_we    = i_mem_wren;
	assign o_wb_sel   = i_bmask;
	assign o_wb_adr   = i_addr;
	assign o_wb_dat_o = i_store_data;

	assign o_stall = access & ~i_wb_ack; // released in the ack cycle.

	// aligned accesses only, so one lane shift covers byte and half.
	assign shifted = i_wb_dat_i >> {i_addr[1:0], 3'b000};

	always_comb begin
		case (i_sl_sel)
			ls_byte:   o_load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
			ls_half:   o_load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
			ls_byte_u: o_load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
			ls_half_u: o_load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
			default:   o_load_data = i_wb_dat_i;
		endcase
	end

endmodule

`default_nettype wire

// ==== wb_data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_data_ram (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_wb_cyc,
	input  logic                     i_wb_stb,
	input  logic                     i_wb_we,
	input  logic [3:0]               i_wb_sel,
	input  logic [rv_pkg::XLEN-1:0]  i_wb_adr,
	input  logic [rv_pkg::XLEN-1:0]  i_wb_dat_i,
	output logic [rv_pkg::XLEN-1:0]  o_wb_dat_o,
	output logic                     o_wb_ack
);
	import rv_pkg::*;

	logic [XLEN-1:0]              mem [MEM_WORDS];
	logic [$clog2(MEM_WORDS)-1:0] word_idx;
	logic                         req;

	assign word_idx = i_wb_adr[$clog2(MEM_WORDS)+1:2]; // upper bits ignored.
	assign req      = i_wb_cyc & i_wb_stb & ~o_wb_ack; // one ack per access.

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (~i_reset)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= req;
	end

	always_ff @(posedge i_clk) begin
		if (req) begin
			if (i_wb_we) begin
				for (int b = 0; b < 4; b++) begin
					if (i_wb_sel[b])
						mem[word_idx][8*b +: 8] <= i_wb_dat_i[8*b +: 8];
				end
			end else begin
				o_wb_dat_o <= mem[word_idx];
			end
		end
	end

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_stall,
	input  logic                      i_insn_vld,
	input  logic                      i_rd_wren,
	input  logic [rv_pkg::REG_AW-1:0] i_rd_addr,
	input  rv_pkg::wb_sel_e           i_wb_sel,
	input  logic [rv_pkg::XLEN-1:0]   i_alu_data,
	input  logic [rv_pkg::XLEN-1:0]   i_load_data,
	input  logic [rv_pkg::XLEN-1:0]   i_pc_four,
	output logic                      o_wb_vld,
	output logic                      o_wb_rd_wren,
	output logic [rv_pkg::REG_AW-1:0] o_wb_rd_addr,
	output logic [rv_pkg::XLEN-1:0]   o_wb_data
);
	import rv_pkg::*;

	logic [XLEN-1:0] sel_data;

	always_comb begin
		case (i_wb_sel)
			wb_mem:     sel_data = i_load_data;
			wb_pc_four: sel_data = i_pc_four;
			default:    sel_data = i_alu_data;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (~i_reset) begin
			o_wb_vld     <= 1'b0;
			o_wb_rd_wren <= 1'b0;
			o_wb_rd_addr <= '0;
			o_wb_data    <= '0;
		end else if (i_stall) begin
			o_wb_vld     <= 1'b0; // bubble.
			o_wb_rd_wren <= 1'b0;
		end else begin
			o_wb_vld     <= i_insn_vld;
			o_wb_rd_wren <= i_insn_vld & i_rd_wren;
			o_wb_rd_addr <= i_rd_addr;
			o_wb_data    <= sel_data;
		end
	end

endmodule

`default_nettype wire

// ==== exmem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module exmem_subsystem (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_insn_vld,
	input  logic [rv_pkg::XLEN-1:0]   i_pc,
	input  logic [rv_pkg::XLEN-1:0]   i_pc_four,
	input  logic [rv_pkg::XLEN-1:0]   i_opa,
	input  logic [rv_pkg::XLEN-1:0]   i_opb,
	input  rv_pkg::alu_op_e           i_alu_op,
	input  logic [rv_pkg::REG_AW-1:0] i_rd_addr,
	input  logic                      i_rd_wren,
	input  logic                      i_mem_wren,
	input  rv_pkg::wb_sel_e           i_wb_sel,
	input  rv_pkg::ls_size_e          i_sl_sel,
	output logic                      o_ready,
	output logic                      o_wb_vld,
	output logic                      o_wb_rd_wren,
	output logic [rv_pkg::REG_AW-1:0] o_wb_rd_addr,
	output logic [rv_pkg::XLEN-1:0]   o_wb_data
);
	import rv_pkg::*;

	logic [XLEN-1:0]   alu_data_ex, store_data_ex;
	logic [3:0]        bmask_ex;
	logic [XLEN-1:0]   pc_four_mem, alu_data_mem, store_data_mem, load_data_mem;
	logic              rd_wren_mem, insn_vld_mem, mem_wren_mem;
	wb_sel_e           wb_sel_mem;
	ls_size_e          sl_sel_mem;
	logic [3:0]        bmask_mem;
	logic [REG_AW-1:0] rd_addr_mem;
	logic              stall;
	logic              wb_cyc, wb_stb, wb_we, wb_ack;
	logic [3:0]        wb_sel;
	logic [XLEN-1:0]   wb_adr, wb_dat_m2s, wb_dat_s2m;

	assign o_ready = ~stall;

	alu_execute alu_execute_inst (
		.i_alu_op     (i_alu_op),
		.i_opa        (i_opa),
		.i_opb        (i_opb),
		.i_pre_opb    (i_opb), // store value.
		.i_sl_sel     (i_sl_sel),
		.o_alu_data   (alu_data_ex),
		.o_bmask      (bmask_ex),
		.o_store_data (store_data_ex)
	);

	flip_flop_execute_memory flip_flop_execute_memory_inst (
		.i_clk              (i_clk),
		.i_reset            (i_reset),
		.i_stall            (stall),
		.i_pc_execute       (i_pc),
		.i_pc_four_execute  (i_pc_four),
		.i_rd_wren_execute  (i_rd_wren),
		.i_insn_vld_execute (i_insn_vld),
		.i_mem_wren_execute (i_mem_wren),
		.i_wb_sel_execute   (i_wb_sel),
		.i_sl_sel_execute   (i_sl_sel),
		.i_bmask_execute    (bmask_ex),
		.i_alu_data_execute (alu_data_ex),
		.i_rd_addr_execute  (i_rd_addr),
		.i_pre_opb_execute  (store_data_ex), // already lane aligned.
		.o_pc_memory        (),
		.o_pc_four_memory   (pc_four_mem),
		.o_rd_wren_memory   (rd_wren_mem),
		.o_insn_vld_memory  (insn_vld_mem),
		.o_mem_wren_memory  (mem_wren_mem),
		.o_wb_sel_memory    (wb_sel_mem),
		.o_sl_sel_memory    (sl_sel_mem),
		.o_bmask_memory     (bmask_mem),
		.o_alu_data_memory  (alu_data_mem),
		.o_rd_addr_memory   (rd_addr_mem),
		.o_pre_opb_memory   (store_data_mem)
	);

	lsu_memory lsu_memory_inst (
		.i_insn_vld   (insn_vld_mem),
		.i_mem_wren   (mem_wren_mem),
		.i_wb_sel     (wb_sel_mem),
		.i_sl_sel     (sl_sel_mem),
		.i_bmask      (bmask_mem),
		.i_addr       (alu_data_mem),
		.i_store_data (store_data_mem),
		.i_wb_dat_i   (wb_dat_s2m),
		.i_wb_ack     (wb_ack),
		.o_wb_cyc     (wb_cyc),
		.o_wb_stb     (wb_stb),
		.o_wb_we      (wb_we),
		.o_wb_sel     (wb_sel),
		.o_wb_adr     (wb_adr),
		.o_wb_dat_o   (wb_dat_m2s),
		.o_stall      (stall),
		.o_load_data  (load_data_mem)
	);

	wb_data_ram wb_data_ram_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_sel   (wb_sel),
		.i_wb_adr   (wb_adr),
		.i_wb_dat_i (wb_dat_m2s),
		.o_wb_dat_o (wb_dat_s2m),
		.o_wb_ack   (wb_ack)
	);

	writeback_stage writeback_stage_inst (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_stall      (stall),
		.i_insn_vld   (insn_vld_mem),
		.i_rd_wren    (rd_wren_mem),
		.i_rd_addr    (rd_addr_mem),
		.i_wb_sel     (wb_sel_mem),
		.i_alu_data   (alu_data_mem),
		.i_load_data  (load_data_mem),
		.i_pc_four    (pc_four_mem),
		.o_wb_vld     (o_wb_vld),
		.o_wb_rd_wren (o_wb_rd_wren),
		.o_wb_rd_addr (o_wb_rd_addr),
		.o_wb_data    (o_wb_data)
	);

endmodule

`default_nettype wire

// ==== tb_exmem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exmem_subsystem;
	import rv_pkg::*;

	logic              i_clk, i_reset, i_insn_vld, i_rd_wren, i_mem_wren;
	logic [XLEN-1:0]   i_pc, i_pc_four, i_opa, i_opb;
	logic [REG_AW-1:0] i_rd_addr;
	alu_op_e           i_alu_op;
	wb_sel_e           i_wb_sel;
	ls_size_e          i_sl_sel;
	logic              o_ready, o_wb_vld, o_wb_rd_wren;
	logic [REG_AW-1:0] o_wb_rd_addr;
	logic [XLEN-1:0]   o_wb_data;

	logic [XLEN-1:0]   mirror [MEM_WORDS];
	logic [37:0]       expect_q [$]; // {wren, rd, data}.

	exmem_subsystem exmem_subsystem_inst (.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, want));
	endtask

	function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			alu_add:    return a + b;
			alu_sub:    return a - b;
			alu_and:    return a & b;
			alu_or:     return a | b;
			alu_xor:    return a ^ b;
			alu_sll:    return a << sh;
			alu_srl:    return a >> sh;
			alu_sra:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			alu_slt:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)}; // bias trick.
			alu_sltu:   return {31'b0, a < b};
			alu_pass_b: return b;
			default:    return 32'h0;
		endcase
	endfunction

	// expected write-back value; stores also update the mirror.
	function automatic logic [31:0] predict(alu_op_e op, logic [31:0] a, logic [31:0] b,
			logic st, wb_sel_e sel, ls_size_e sz, logic [31:0] pc4);
		logic [31:0] res;
		logic [31:0] word;
		logic [7:0]  idx;
		res  = alu_ref(op, a, b);
		idx  = res[9:2];
		word = mirror[idx] >> (8 * res[1:0]);
		if (st) begin
			case (sz)
				ls_byte, ls_byte_u: mirror[idx][8*res[1:0] +: 8] = b[7:0];
				ls_half, ls_half_u: mirror[idx][16*res[1] +: 16] = b[15:0];
				default:            mirror[idx] = b;
			endcase
		end
		case (sel)
			wb_pc_four: return pc4;
			wb_mem: begin
				case (sz)
					ls_byte:   return {{24{word[7]}}, word[7:0]};
					ls_half:   return {{16{word[15]}}, word[15:0]};
					ls_byte_u: return {24'h0, word[7:0]};
					ls_half_u: return {16'h0, word[15:0]};
					default:   return word;
				endcase
			end
			default: return res;
		endcase
	endfunction

	function automatic logic [31:0] fill_word(int idx);
		return (idx * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] align(logic [31:0] a, ls_size_e sz);
		if (sz == ls_word)
			a[1:0] = 2'b00;
		else if (sz == ls_half || sz == ls_half_u)
			a[0] = 1'b0;
		return a;
	endfunction

	function automatic logic [31:0] rand_addr(ls_size_e sz);
		return align($urandom_range(0, 4 * MEM_WORDS - 1), sz);
	endfunction

	task automatic issue(alu_op_e op, logic [31:0] a, logic [31:0] b, logic [4:0] rd,
			logic wren, logic st, wb_sel_e sel, ls_size_e sz);
		int          waited;
		logic [31:0] pc;
		waited       = 0;
		pc           = $urandom & 32'hffff_fffc;
		i_insn_vld   = 1'b1;
		i_alu_op     = op;
		i_opa        = a;
		i_opb        = b;
		i_rd_addr    = rd;
		i_rd_wren    = wren;
		i_mem_wren   = st;
		i_wb_sel     = sel;
		i_sl_sel     = sz;
		i_pc         = pc;
		i_pc_four    = pc + 32'd4;
		while (!o_ready) begin // held until the next edge can take it.
			@(negedge i_clk);
			waited++;
			if (waited > 20)
				abort_run("o_ready stayed low too long while an instruction was waiting");
		end
		expect_q.push_back({wren, rd, predict(op, a, b, st, sel, sz, pc + 32'd4)});
		@(negedge i_clk);
		i_insn_vld = 1'b0;
	endtask

	task automatic idle(int n);
		repeat (n) @(negedge i_clk);
	endtask

	task automatic store(logic [31:0] addr, ls_size_e sz, logic [31:0] val);
		issue(alu_add, addr - val, val, 5'($urandom), 1'b0, 1'b1, wb_alu, sz); // opb is the data.
	endtask

	task automatic load(logic [31:0] addr, ls_size_e sz);
		logic [31:0] b;
		b = $urandom;
		issue(alu_add, addr - b, b, 5'($urandom), 1'b1, 1'b0, wb_mem, sz);
	endtask

	task automatic alu_insn(alu_op_e op, logic [31:0] a, logic [31:0] b);
		issue(op, a, b, 5'($urandom), 1'b1, 1'b0, wb_alu, ls_word);
	endtask

	initial begin
		logic [37:0] want;
		forever begin
			@(negedge i_clk);
			if (o_wb_vld === 1'b1) begin
				if (expect_q.size() == 0)
					abort_run("write-back valid seen with no instruction outstanding");
				want = expect_q.pop_front();
				check("o_wb_rd_wren", o_wb_rd_wren, want[37]);
				check("o_wb_rd_addr", o_wb_rd_addr, want[36:32]);
				check("o_wb_data", o_wb_data, want[31:0]);
			end
		end
	end

	initial begin
		for (int c = 0; c < 20000; c++)
			@(posedge i_clk);
		abort_run("global timeout, the run did not finish within 20000 cycles");
	end

	initial begin
		logic [31:0] a;
		ls_size_e    ssz;
		int          waited;
		void'($urandom(32'hea181a30));
		i_reset    = 1'b0;
		i_insn_vld = 1'b0;
		i_pc       = '0;
		i_pc_four  = '0;
		i_opa      = '0;
		i_opb      = '0;
		i_alu_op   = alu_add;
		i_rd_addr  = '0;
		i_rd_wren  = 1'b0;
		i_mem_wren = 1'b0;
		i_wb_sel   = wb_alu;
		i_sl_sel   = ls_word;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b1;
		check("o_wb_vld", o_wb_vld, 32'd0);
		check("o_ready", o_ready, 32'd1);
		for (int i = 0; i < MEM_WORDS; i++)
			store(i * 4, ls_word, fill_word(i)); // ram powers up unknown.
		for (int op = 0; op <= alu_pass_b; op++) begin
			alu_insn(alu_op_e'(op), $urandom, $urandom);
			alu_insn(alu_op_e'(op), $urandom, 32'd31);
			alu_insn(alu_op_e'(op), 32'h8000_0000, 32'h0000_0001);
			alu_insn(alu_op_e'(op), 32'h7fff_ffff, 32'hffff_ffff);
		end
		for (int k = 0; k < 8; k++)
			issue(alu_op_e'($urandom_range(0, 10)), $urandom, $urandom, 5'($urandom),
				k[0], 1'b0, wb_pc_four, ls_word);
		for (int k = 0; k < 9; k++) begin
			ssz = (k % 3 == 0) ? ls_word : (k % 3 == 1) ? ls_half : ls_byte;
			a   = rand_addr(ssz);
			store(a, ssz, $urandom);
			for (int s = 0; s <= ls_half_u; s++)
				load(align(a, ls_size_e'(s)), ls_size_e'(s));
		end
		// back-pressure with no idle cycles between.
		for (int k = 0; k < 10; k++) begin
			alu_insn(alu_op_e'($urandom_range(0, 10)), $urandom, $urandom);
			ssz = ls_size_e'($urandom_range(0, 4));
			load(rand_addr(ssz), ssz);
			store(rand_addr(ssz), ssz, $urandom);
			load(rand_addr(ssz), ssz);
		end
		for (int k = 0; k < 300; k++) begin
			ssz = ls_size_e'($urandom_range(0, 4));
			case ($urandom_range(0, 3))
				0: alu_insn(alu_op_e'($urandom_range(0, 10)), $urandom, $urandom);
				1: issue(alu_add, $urandom, $urandom, 5'($urandom), 1'b1, 1'b0, wb_pc_four, ssz);
				2: store(rand_addr(ssz), ssz, $urandom);
				default: load(rand_addr(ssz), ssz);
			endcase
			idle($urandom_range(0, 3));
		end
		waited = 0;
		while (expect_q.size() != 0) begin
			@(negedge i_clk);
			waited++;
			if (waited > 50)
				abort_run("pipeline did not drain all outstanding results");
		end
		idle(4);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
rv_pkg.sv
alu_execute.sv
flip_flop_execute_memory.sv
lsu_memory.sv
wb_data_ram.sv
writeback_stage.sv
exmem_subsystem.sv
tb_exmem_subsystem.sv
